/* list.f */
logic/soc_pkg.sv
logic/wb_if.sv
logic/wb_decoder.sv
logic/gpio_ctrl.sv
logic/seg7_scan.sv
logic/sync_fifo.sv
logic/uart_core.sv
logic/board_soc_top.sv
tb/tb_board_soc.sv

/* logic/board_soc_top.sv */
`timescale 1ns/1ns

module board_soc_top import soc_pkg::*; (
    input  logic                clk,
    input  logic                rst_i,
    // Wishbone slave port
    input  logic                wb_cyc_i,
    input  logic                wb_stb_i,
    input  logic                wb_we_i,
    input  logic [ADDR_W-1:0]   wb_adr_i,
    input  logic [DATA_W-1:0]   wb_dat_i,
    output logic [DATA_W-1:0]   wb_dat_o,
    output logic                wb_ack_o,
    // UART
    input  logic                uart_rxd_i,
    output logic                uart_txd_o,
    // LEDs, switches, step buttons
    output logic [LED_W-1:0]    led_o,
    input  logic [SWITCH_W-1:0] switch_i,
    input  logic [BTN_W-1:0]    btn_step_i,
    // Seven-segment display
    output logic [DIGITS-1:0]   num_csn_o,
    output logic [SEG_W-1:0]    num_a_g_o,
    output logic                num_dp_o
);

    wb_if gpio_bus ();
    wb_if seg_bus ();
    wb_if uart_bus ();

    wb_decoder u_decoder (
        .clk      (clk),
        .rst_i    (rst_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .gpio_bus (gpio_bus.master),
        .seg_bus  (seg_bus.master),
        .uart_bus (uart_bus.master)
    );

    gpio_ctrl u_gpio (
        .clk        (clk),
        .rst_i      (rst_i),
        .bus        (gpio_bus.slave),
        .led_o      (led_o),
        .switch_i   (switch_i),
        .btn_step_i (btn_step_i)
    );

    seg7_scan u_seg7 (
        .clk       (clk),
        .rst_i     (rst_i),
        .bus       (seg_bus.slave),
        .num_csn_o (num_csn_o),
        .num_a_g_o (num_a_g_o),
        .num_dp_o  (num_dp_o)
    );

    uart_core u_uart (
        .clk        (clk),
        .rst_i      (rst_i),
        .bus        (uart_bus.slave),
        .uart_rxd_i (uart_rxd_i),
        .uart_txd_o (uart_txd_o)
    );

endmodule

/* logic/gpio_ctrl.sv */
`timescale 1ns/1ns

module gpio_ctrl import soc_pkg::*; (
    input  logic                clk,
    input  logic                rst_i,
    wb_if.slave                 bus,
    output logic [LED_W-1:0]    led_o,
    input  logic [SWITCH_W-1:0] switch_i,
    input  logic [BTN_W-1:0]    btn_step_i
);

    logic                      req;
    logic [LED_W-1:0]          led_q;
    logic [BTN_W+SWITCH_W-1:0] in_meta;
    logic [BTN_W+SWITCH_W-1:0] in_sync;

    // New transfer, not yet acknowledged
    assign req = bus.cyc && bus.stb && !bus.ack;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            bus.ack <= 1'b0;
            led_q   <= '0;
        end else begin
            bus.ack <= req;
            if (req && bus.we && bus.adr == REG_LED)
                led_q <= bus.dat_w[LED_W-1:0];
        end
    end

    // Two-stage synchronizer for switches and buttons
    always_ff @(posedge clk) begin
        in_meta <= {btn_step_i, switch_i};
        in_sync <= in_meta;
    end

    // Read data captured with the ack
    always_ff @(posedge clk) begin
        if (req) begin
            case (bus.adr)
                REG_LED:   bus.dat_r <= DATA_W'(led_q);
                REG_INPUT: bus.dat_r <= DATA_W'(in_sync);
                default:   bus.dat_r <= '0;
            endcase
        end
    end

    assign led_o = led_q;

endmodule

/* logic/seg7_scan.sv */
`timescale 1ns/1ns

module seg7_scan import soc_pkg::*; (
    input  logic              clk,
    input  logic              rst_i,
    wb_if.slave               bus,
    output logic [DIGITS-1:0] num_csn_o,
    output logic [SEG_W-1:0]  num_a_g_o,
    output logic              num_dp_o
);

    logic                   req;
    logic [4*DIGITS-1:0]    digits_q;
    logic [SCAN_CNT_W-1:0]  scan_cnt;
    logic [DIGIT_IDX_W-1:0] digit_idx;

    // Hex to segments, bit 0 is segment a
    function automatic logic [SEG_W-1:0] hex_to_seg(input logic [3:0] nib);
        case (nib)
            4'h0: return 7'h3f;
            4'h1: return 7'h06;
            4'h2: return 7'h5b;
            4'h3: return 7'h4f;
            4'h4: return 7'h66;
            4'h5: return 7'h6d;
            4'h6: return 7'h7d;
            4'h7: return 7'h07;
            4'h8: return 7'h7f;
            4'h9: return 7'h6f;
            4'ha: return 7'h77;
            4'hb: return 7'h7c;
            4'hc: return 7'h39;
            4'hd: return 7'h5e;
            4'he: return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    assign req = bus.cyc && bus.stb && !bus.ack;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            bus.ack   <= 1'b0;
            digits_q  <= '0;
            scan_cnt  <= '0;
            digit_idx <= '0;
        end else begin
            bus.ack <= req;
            if (req && bus.we && bus.adr == REG_DIGITS)
                digits_q <= bus.dat_w[4*DIGITS-1:0];
            // Next digit every SCAN_CLKS cycles, wraps after 7
            if (scan_cnt == SCAN_CNT_W'(SCAN_CLKS - 1)) begin
                scan_cnt  <= '0;
                digit_idx <= digit_idx + 1'b1;
            end else begin
                scan_cnt <= scan_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req)
            bus.dat_r <= (bus.adr == REG_DIGITS) ? DATA_W'(digits_q) : '0;
    end

    assign num_csn_o = ~(DIGITS'(1) << digit_idx);
    assign num_a_g_o = hex_to_seg(digits_q[digit_idx*4 +: 4]);
    assign num_dp_o  = 1'b0;

    // The low select bit moves one digit up at the end of each scan interval
    a_scan_step: assert property (
        @(posedge clk) disable iff (rst_i)
        scan_cnt == SCAN_CNT_W'(SCAN_CLKS - 1)
            |=> num_csn_o == {$past(num_csn_o[DIGITS-2:0]), $past(num_csn_o[DIGITS-1])}
    );

endmodule

/* logic/soc_pkg.sv */
package soc_pkg;

    // Wishbone word address and data
    localparam int ADDR_W   = 6;
    localparam int DATA_W   = 32;
    localparam int REGION_W = 2;
    localparam int OFFS_W   = ADDR_W - REGION_W;

    // Peripheral regions, picked by the top address bits
    localparam logic [REGION_W-1:0] REGION_GPIO = 2'd0;
    localparam logic [REGION_W-1:0] REGION_SEG  = 2'd1;
    localparam logic [REGION_W-1:0] REGION_UART = 2'd2;

    // Register offsets within a region
    localparam logic [OFFS_W-1:0] REG_LED       = 4'd0;
    localparam logic [OFFS_W-1:0] REG_INPUT     = 4'd1;
    localparam logic [OFFS_W-1:0] REG_DIGITS    = 4'd0;
    localparam logic [OFFS_W-1:0] REG_UART_DATA = 4'd0;
    localparam logic [OFFS_W-1:0] REG_UART_STAT = 4'd1;

    // Board pin widths
    localparam int LED_W    = 16;
    localparam int SWITCH_W = 8;
    localparam int BTN_W    = 2;
    localparam int DIGITS   = 8;
    localparam int SEG_W    = 7;

    // Display scan
    localparam int SCAN_CLKS   = 8;
    localparam int SCAN_CNT_W  = $clog2(SCAN_CLKS);
    localparam int DIGIT_IDX_W = $clog2(DIGITS);

    // UART timing and buffering
    localparam int UART_BIT_CLKS = 16;
    localparam int UART_CNT_W    = $clog2(UART_BIT_CLKS);
    localparam int FIFO_DEPTH    = 4;

    typedef logic [7:0] uart_byte_t;

    // Receive FIFO entry, frame error above the byte
    typedef struct packed {
        logic       frame_err;
        uart_byte_t data;
    } uart_rx_entry_t;

endpackage

/* logic/sync_fifo.sv */
`timescale 1ns/1ns

module sync_fifo import soc_pkg::*; #(
    parameter type payload_t = uart_byte_t,
    parameter int  DEPTH     = FIFO_DEPTH
) (
    input  logic     clk,
    input  logic     rst_i,
    input  logic     push_i,
    input  payload_t push_data_i,
    input  logic     pop_i,
    output payload_t pop_data_o,
    output logic     full_o,
    output logic     empty_o
);

    payload_t                   mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i)
                wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            if (pop_i)
                rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            if (push_i && !pop_i)
                count <= count + 1'b1;
            else if (pop_i && !push_i)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push_i)
            mem[wr_ptr] <= push_data_i;
    end

    // Head entry is visible before the pop
    assign pop_data_o = mem[rd_ptr];
    assign full_o     = count == DEPTH;
    assign empty_o    = count == 0;

    a_no_overflow:  assert property (@(posedge clk) disable iff (rst_i) push_i |-> !full_o);
    a_no_underflow: assert property (@(posedge clk) disable iff (rst_i) pop_i |-> !empty_o);

endmodule

/* logic/uart_core.sv */
`timescale 1ns/1ns

module uart_core import soc_pkg::*; (
    input  logic clk,
    input  logic rst_i,
    wb_if.slave  bus,
    input  logic uart_rxd_i,
    output logic uart_txd_o
);

    logic                  req;
    logic                  wr_data;
    logic                  rd_data;
    logic                  rd_stat;
    logic                  tx_full;
    logic                  tx_empty;
    logic                  tx_pop;
    uart_byte_t            tx_head;
    logic                  tx_busy;
    logic [9:0]            tx_shift;
    logic [UART_CNT_W-1:0] tx_clk_cnt;
    logic [3:0]            tx_bit_cnt;
    logic                  rxd_meta;
    logic                  rxd_sync;
    logic                  rxd_prev;
    logic                  rx_busy;
    logic [UART_CNT_W-1:0] rx_clk_cnt;
    logic [3:0]            rx_bit_cnt;
    uart_byte_t            rx_data;
    logic                  rx_sample;
    logic                  rx_done;
    logic                  rx_full;
    logic                  rx_empty;
    uart_rx_entry_t        rx_entry;
    uart_rx_entry_t        rx_head;
    logic                  overrun;

    assign req     = bus.cyc && bus.stb && !bus.ack;
    assign wr_data = req && bus.we && bus.adr == REG_UART_DATA;
    assign rd_data = req && !bus.we && bus.adr == REG_UART_DATA;
    assign rd_stat = req && !bus.we && bus.adr == REG_UART_STAT;

    // Writes while full are dropped here
    sync_fifo #(.payload_t(uart_byte_t)) u_tx_fifo (
        .clk         (clk),
        .rst_i       (rst_i),
        .push_i      (wr_data && !tx_full),
        .push_data_i (bus.dat_w[7:0]),
        .pop_i       (tx_pop),
        .pop_data_o  (tx_head),
        .full_o      (tx_full),
        .empty_o     (tx_empty)
    );

    sync_fifo #(.payload_t(uart_rx_entry_t)) u_rx_fifo (
        .clk         (clk),
        .rst_i       (rst_i),
        .push_i      (rx_done && !rx_full),
        .push_data_i (rx_entry),
        .pop_i       (rd_data && !rx_empty),
        .pop_data_o  (rx_head),
        .full_o      (rx_full),
        .empty_o     (rx_empty)
    );

    // Transmit shifter, stop/data/start loaded in one go
    assign tx_pop     = !tx_busy && !tx_empty;
    assign uart_txd_o = tx_shift[0];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            tx_busy    <= 1'b0;
            tx_shift   <= '1;
            tx_clk_cnt <= '0;
            tx_bit_cnt <= '0;
        end else if (tx_pop) begin
            tx_busy    <= 1'b1;
            tx_shift   <= {1'b1, tx_head, 1'b0};
            tx_clk_cnt <= '0;
            tx_bit_cnt <= '0;
        end else if (tx_busy) begin
            if (tx_clk_cnt == UART_CNT_W'(UART_BIT_CLKS - 1)) begin
                tx_clk_cnt <= '0;
                tx_shift   <= {1'b1, tx_shift[9:1]};
                tx_bit_cnt <= tx_bit_cnt + 1'b1;
                if (tx_bit_cnt == 4'd9)
                    tx_busy <= 1'b0;
            end else begin
                tx_clk_cnt <= tx_clk_cnt + 1'b1;
            end
        end
    end

    // Line synchronizer plus one stage for edge detect
    always_ff @(posedge clk) begin
        if (rst_i) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= uart_rxd_i;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    // Sample point is the middle of each bit
    assign rx_sample = rx_busy && rx_clk_cnt == UART_CNT_W'(UART_BIT_CLKS / 2 - 1);
    assign rx_done   = rx_sample && rx_bit_cnt == 4'd9;
    assign rx_entry  = '{frame_err: !rxd_sync, data: rx_data};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rx_busy    <= 1'b0;
            rx_clk_cnt <= '0;
            rx_bit_cnt <= '0;
        end else if (!rx_busy) begin
            if (rxd_prev && !rxd_sync) begin
                rx_busy    <= 1'b1;
                rx_clk_cnt <= '0;
                rx_bit_cnt <= '0;
            end
        end else begin
            if (rx_clk_cnt == UART_CNT_W'(UART_BIT_CLKS - 1))
                rx_clk_cnt <= '0;
            else
                rx_clk_cnt <= rx_clk_cnt + 1'b1;
            if (rx_sample) begin
                rx_bit_cnt <= rx_bit_cnt + 1'b1;
                // Glitch on the start bit, or the stop bit reached
                if ((rx_bit_cnt == 4'd0 && rxd_sync) || rx_done)
                    rx_busy <= 1'b0;
            end
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk) begin
        if (rx_sample && rx_bit_cnt != 4'd0 && rx_bit_cnt != 4'd9)
            rx_data <= {rxd_sync, rx_data[7:1]};
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            bus.ack <= 1'b0;
            overrun <= 1'b0;
        end else begin
            bus.ack <= req;
            // A new overrun wins over the clearing read
            if (rx_done && rx_full)
                overrun <= 1'b1;
            else if (rd_stat)
                overrun <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_data)
            bus.dat_r <= rx_empty ? '0 : DATA_W'({1'b1, rx_head});
        else if (rd_stat)
            bus.dat_r <= DATA_W'({overrun, tx_empty && !tx_busy, tx_full, !rx_empty});
        else if (req)
            bus.dat_r <= '0;
    end

endmodule

/* logic/wb_decoder.sv */
`timescale 1ns/1ns

module wb_decoder import soc_pkg::*; (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              wb_cyc_i,
    input  logic              wb_stb_i,
    input  logic              wb_we_i,
    input  logic [ADDR_W-1:0] wb_adr_i,
    input  logic [DATA_W-1:0] wb_dat_i,
    output logic [DATA_W-1:0] wb_dat_o,
    output logic              wb_ack_o,
    wb_if.master              gpio_bus,
    wb_if.master              seg_bus,
    wb_if.master              uart_bus
);

    logic [REGION_W-1:0] region;
    logic                sel_gpio;
    logic                sel_seg;
    logic                sel_uart;
    logic                unmapped_ack;

    assign region   = wb_adr_i[ADDR_W-1 -: REGION_W];
    assign sel_gpio = region == REGION_GPIO;
    assign sel_seg  = region == REGION_SEG;
    assign sel_uart = region == REGION_UART;

    // Everything but stb is shared by all buses
    assign gpio_bus.cyc   = wb_cyc_i;
    assign gpio_bus.stb   = wb_stb_i && sel_gpio;
    assign gpio_bus.we    = wb_we_i;
    assign gpio_bus.adr   = wb_adr_i[OFFS_W-1:0];
    assign gpio_bus.dat_w = wb_dat_i;

    assign seg_bus.cyc   = wb_cyc_i;
    assign seg_bus.stb   = wb_stb_i && sel_seg;
    assign seg_bus.we    = wb_we_i;
    assign seg_bus.adr   = wb_adr_i[OFFS_W-1:0];
    assign seg_bus.dat_w = wb_dat_i;

    assign uart_bus.cyc   = wb_cyc_i;
    assign uart_bus.stb   = wb_stb_i && sel_uart;
    assign uart_bus.we    = wb_we_i;
    assign uart_bus.adr   = wb_adr_i[OFFS_W-1:0];
    assign uart_bus.dat_w = wb_dat_i;

    // Unmapped region answers by itself, same timing as a peripheral
    always_ff @(posedge clk) begin
        if (rst_i)
            unmapped_ack <= 1'b0;
        else
            unmapped_ack <= wb_cyc_i && wb_stb_i && !(sel_gpio || sel_seg || sel_uart)
                            && !unmapped_ack;
    end

    always_comb begin
        wb_dat_o = '0;
        wb_ack_o = unmapped_ack;
        if (sel_gpio) begin
            wb_dat_o = gpio_bus.dat_r;
            wb_ack_o = gpio_bus.ack;
        end else if (sel_seg) begin
            wb_dat_o = seg_bus.dat_r;
            wb_ack_o = seg_bus.ack;
        end else if (sel_uart) begin
            wb_dat_o = uart_bus.dat_r;
            wb_ack_o = uart_bus.ack;
        end
    end

    // Acks from every peripheral only ever answer a live strobe
    a_ack_needs_stb: assert property (
        @(posedge clk) disable iff (rst_i) wb_ack_o |-> wb_cyc_i && wb_stb_i
    );

endmodule

/* logic/wb_if.sv */
`timescale 1ns/1ns

interface wb_if import soc_pkg::*; ();

    logic              cyc;
    logic              stb;
    logic              we;
    logic [OFFS_W-1:0] adr;
    logic [DATA_W-1:0] dat_w;
    logic [DATA_W-1:0] dat_r;
    logic              ack;

    // Decoder side
    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    // Peripheral side
    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

/* tb/tb_board_soc.sv */
`timescale 1ns/1ns

module tb_board_soc import soc_pkg::*; ();

    logic                clk;
    logic                rst_i;
    logic                wb_cyc_i;
    logic                wb_stb_i;
    logic                wb_we_i;
    logic [ADDR_W-1:0]   wb_adr_i;
    logic [DATA_W-1:0]   wb_dat_i;
    logic [DATA_W-1:0]   wb_dat_o;
    logic                wb_ack_o;
    logic                uart_rxd_i;
    logic                uart_txd_o;
    logic [LED_W-1:0]    led_o;
    logic [SWITCH_W-1:0] switch_i;
    logic [BTN_W-1:0]    btn_step_i;
    logic [DIGITS-1:0]   num_csn_o;
    logic [SEG_W-1:0]    num_a_g_o;
    logic                num_dp_o;

    integer seed;

    // Register model
    logic [LED_W-1:0]    led_model;
    logic [4*DIGITS-1:0] digits_model;

    // Bytes decoded from txd, and the line decoder state
    logic [7:0] tx_seen [$];
    logic       mon_busy;
    integer     mon_cnt;
    integer     mon_bit;
    logic [7:0] mon_byte;

    board_soc_top DUT (
        .clk        (clk),
        .rst_i      (rst_i),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o),
        .uart_rxd_i (uart_rxd_i),
        .uart_txd_o (uart_txd_o),
        .led_o      (led_o),
        .switch_i   (switch_i),
        .btn_step_i (btn_step_i),
        .num_csn_o  (num_csn_o),
        .num_a_g_o  (num_a_g_o),
        .num_dp_o   (num_dp_o)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
            abort_run($sformatf("Mismatch %s expected %h actual %h", name, expected, actual));
    endtask

    function automatic logic [ADDR_W-1:0] reg_addr(input logic [REGION_W-1:0] region,
                                                   input logic [OFFS_W-1:0] offs);
        return {region, offs};
    endfunction

    // Segment pattern as gfedcba
    function automatic logic [SEG_W-1:0] seg_pattern(input logic [3:0] nib);
        case (nib)
            4'h0: return 7'b0111111;
            4'h1: return 7'b0000110;
            4'h2: return 7'b1011011;
            4'h3: return 7'b1001111;
            4'h4: return 7'b1100110;
            4'h5: return 7'b1101101;
            4'h6: return 7'b1111101;
            4'h7: return 7'b0000111;
            4'h8: return 7'b1111111;
            4'h9: return 7'b1101111;
            4'ha: return 7'b1110111;
            4'hb: return 7'b1111100;
            4'hc: return 7'b0111001;
            4'hd: return 7'b1011110;
            4'he: return 7'b1111001;
            default: return 7'b1110001;
        endcase
    endfunction

    // One classic cycle, ack expected right after the edge that sees stb
    task automatic wb_transfer(input logic we, input logic [ADDR_W-1:0] adr,
                               input logic [DATA_W-1:0] wdata,
                               output logic [DATA_W-1:0] rdata);
        integer waited;
        @(posedge clk);
        #1;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdata;
        @(posedge clk);
        @(negedge clk);
        waited = 1;
        while (!wb_ack_o && waited < 8) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (!wb_ack_o)
            abort_run($sformatf("No ack came back for an access to address %h", adr));
        check_value("ack latency", 1, waited);
        rdata = wb_dat_o;
        @(posedge clk);
        #1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        @(negedge clk);
        check_value("single ack", 0, wb_ack_o);
    endtask

    task automatic write_reg(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] unused;
        wb_transfer(1'b1, adr, data, unused);
    endtask

    task automatic read_reg(input logic [ADDR_W-1:0] adr, output logic [DATA_W-1:0] data);
        wb_transfer(1'b0, adr, '0, data);
    endtask

    // Polls UART status until one bit takes the wanted value
    task automatic wait_status(input integer bit_idx, input logic value, input string what);
        logic [DATA_W-1:0] stat;
        integer            polls;
        polls = 0;
        read_reg(reg_addr(REGION_UART, REG_UART_STAT), stat);
        while (stat[bit_idx] !== value && polls < 2000) begin
            read_reg(reg_addr(REGION_UART, REG_UART_STAT), stat);
            polls = polls + 1;
        end
        if (stat[bit_idx] !== value)
            abort_run({"Timed out waiting for UART status: ", what});
    endtask

    // Start, eight data bits LSB first, stop, then one idle bit time
    task automatic send_frame(input logic [7:0] data, input logic bad_stop);
        logic [10:0] bits;
        bits = {1'b1, !bad_stop, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge clk);
            #1;
            uart_rxd_i = bits[i];
            repeat (UART_BIT_CLKS - 1) @(posedge clk);
        end
    endtask

    // txd decoder, bit middles counted from the first low sample
    always @(negedge clk) begin
        if (rst_i) begin
            mon_busy = 1'b0;
        end else if (!mon_busy) begin
            if (uart_txd_o === 1'b0) begin
                mon_busy = 1'b1;
                mon_cnt  = 0;
                mon_bit  = 0;
            end
        end else begin
            mon_cnt = mon_cnt + 1;
            if (mon_cnt == UART_BIT_CLKS / 2 + mon_bit * UART_BIT_CLKS) begin
                if (mon_bit == 0 && uart_txd_o !== 1'b0) begin
                    abort_run("Start bit on txd did not stay low");
                end else if (mon_bit >= 1 && mon_bit <= 8) begin
                    mon_byte[mon_bit-1] = uart_txd_o;
                end else if (mon_bit == 9) begin
                    if (uart_txd_o !== 1'b1)
                        abort_run("Stop bit on txd was not high");
                    tx_seen.push_back(mon_byte);
                    mon_busy = 1'b0;
                end
                mon_bit = mon_bit + 1;
            end
        end
    end

    initial begin
        logic [DATA_W-1:0] rdata;
        logic [7:0]        sent [$];
        logic [7:0]        rx_bytes [$];
        logic [7:0]        bval;
        logic              bad;
        logic [DIGITS-1:0] seen;
        integer            low_cnt;
        integer            idx;
        integer            polls;

        seed         = 32'hd82e_404b;
        clk          = 1'b0;
        rst_i        = 1'b1;
        wb_cyc_i     = 1'b0;
        wb_stb_i     = 1'b0;
        wb_we_i      = 1'b0;
        wb_adr_i     = '0;
        wb_dat_i     = '0;
        uart_rxd_i   = 1'b1;
        switch_i     = '0;
        btn_step_i   = '0;
        mon_busy     = 1'b0;
        led_model    = '0;
        digits_model = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_i = 1'b0;

        // Reset state and the unmapped region
        @(negedge clk);
        check_value("reset ack", 0, wb_ack_o);
        check_value("reset led", 0, led_o);
        check_value("reset txd", 1, uart_txd_o);
        check_value("reset digit select", 8'hfe, num_csn_o);
        read_reg(reg_addr(REGION_SEG, REG_DIGITS), rdata);
        check_value("reset digits", 0, rdata);
        write_reg(reg_addr(2'd3, OFFS_W'($random(seed))), $random(seed));
        read_reg(reg_addr(2'd3, OFFS_W'($random(seed))), rdata);
        check_value("unmapped read", 0, rdata);

        // GPIO
        repeat (6) begin
            led_model = LED_W'($random(seed));
            write_reg(reg_addr(REGION_GPIO, REG_LED), DATA_W'(led_model));
            check_value("led pins", led_model, led_o);
            read_reg(reg_addr(REGION_GPIO, REG_LED), rdata);
            check_value("led readback", led_model, rdata);
            @(posedge clk);
            #1;
            switch_i   = SWITCH_W'($random(seed));
            btn_step_i = BTN_W'($random(seed));
            repeat (4) @(posedge clk);
            read_reg(reg_addr(REGION_GPIO, REG_INPUT), rdata);
            check_value("switch and button input", {btn_step_i, switch_i}, rdata);
        end

        // Seven-segment scan
        digits_model = $random(seed);
        write_reg(reg_addr(REGION_SEG, REG_DIGITS), digits_model);
        read_reg(reg_addr(REGION_SEG, REG_DIGITS), rdata);
        check_value("digits readback", digits_model, rdata);
        seen = '0;
        repeat (64) begin
            @(negedge clk);
            low_cnt = 0;
            idx     = 0;
            for (int k = 0; k < DIGITS; k++) begin
                if (!num_csn_o[k]) begin
                    low_cnt = low_cnt + 1;
                    idx     = k;
                end
            end
            check_value("digit selects low", 1, low_cnt);
            check_value("segments", seg_pattern(digits_model[idx*4 +: 4]), num_a_g_o);
            check_value("decimal point", 0, num_dp_o);
            seen[idx] = 1'b1;
        end
        check_value("digits scanned", 8'hff, seen);

        // UART transmit, writes paced by the tx full flag
        repeat (10) begin
            wait_status(1, 1'b0, "tx FIFO space");
            bval = $random(seed);
            write_reg(reg_addr(REGION_UART, REG_UART_DATA), bval);
            sent.push_back(bval);
        end
        wait_status(2, 1'b1, "tx idle");
        polls = 0;
        while (tx_seen.size() < sent.size() && polls < 4 * UART_BIT_CLKS) begin
            @(posedge clk);
            polls = polls + 1;
        end
        if (tx_seen.size() < sent.size())
            abort_run("Timed out waiting for the transmitted bytes on txd");
        check_value("tx byte count", sent.size(), tx_seen.size());
        foreach (sent[i])
            check_value("tx byte", sent[i], tx_seen[i]);
        read_reg(reg_addr(REGION_UART, REG_UART_STAT), rdata);
        check_value("tx idle at end", 1, rdata[2]);

        // UART receive, every third frame with a bad stop bit
        for (int i = 0; i < 8; i++) begin
            bval = $random(seed);
            bad  = (i % 3) == 1;
            send_frame(bval, bad);
            wait_status(0, 1'b1, "received byte");
            read_reg(reg_addr(REGION_UART, REG_UART_DATA), rdata);
            check_value("rx entry", {22'd0, 1'b1, bad, bval}, rdata);
        end
        read_reg(reg_addr(REGION_UART, REG_UART_DATA), rdata);
        check_value("rx empty read", 0, rdata);

        // One frame more than the receive FIFO holds
        repeat (FIFO_DEPTH + 1) begin
            bval = $random(seed);
            rx_bytes.push_back(bval);
            send_frame(bval, 1'b0);
        end
        read_reg(reg_addr(REGION_UART, REG_UART_STAT), rdata);
        check_value("overrun set", 1, rdata[3]);
        check_value("rx not empty", 1, rdata[0]);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            read_reg(reg_addr(REGION_UART, REG_UART_DATA), rdata);
            check_value("overrun rx entry", {22'd0, 1'b1, 1'b0, rx_bytes[i]}, rdata);
        end
        read_reg(reg_addr(REGION_UART, REG_UART_STAT), rdata);
        check_value("overrun cleared", 0, rdata[3]);
        check_value("rx drained", 0, rdata[0]);

        $display("Test OK");
        $finish;
    end

endmodule
